// ==== test/axi_mbox_trace.txt ====
# columns: kind f1 f2 f3, hex. 0 lwrite addr data strb, 1 lread addr expected 0
# 2 remote write addr data strb, 3 stray beat user data 0, 4 irq count n, 5 wait n, 6 half beat addr 0 strb
5 8 0 0
4 0 0 0
1 2000 00000000 0
1 2004 00000000 0
1 2008 00000000 0
1 200c 00000000 0
1 2010 00000000 0
1 2014 00000000 0
1 2018 00000000 0
1 201c 00000000 0
0 2004 11223344 f
0 2004 aabbccdd 5
0 2004 99887766 8
1 2004 99bb33dd 0
0 2008 12345678 3
1 2008 00005678 0
0 2100 ffffffff f
1 2100 00000001 0
2 200c cafef00d f
5 14 0 0
4 1 0 0
1 2104 00000001 0
1 200c cafef00d 0
0 2104 00000000 f
1 2104 00000001 0
0 2104 00000001 f
1 2104 00000000 0
0 2100 00000000 f
1 2100 00000000 0
2 2010 0badbeef f
5 14 0 0
4 1 0 0
1 2010 0badbeef 0
1 2104 00000000 0
0 2100 00000001 1
6 2014 0 f
3 2 55555555 0
2 2018 13579bdf f
5 14 0 0
4 2 0 0
1 2014 00000000 0
1 2018 13579bdf 0
0 2104 00000001 1
1 2040 ffffffff 0
1 2800 ffffffff 0
1 7000 ffffffff 0
0 2040 deadbeef f
0 7000 deadbeef f
0 2000 01010101 f
2 201c 70707070 f
0 2000 02020202 2
2 201c 7171aaaa c
0 2004 44444444 1
2 2008 88888888 4
5 1e 0 0
4 5 0 0
1 2000 01010201 0
1 2004 99bb3344 0
1 2008 00885678 0
1 200c cafef00d 0
1 2010 0badbeef 0
1 2014 00000000 0
1 2018 13579bdf 0
1 201c 71717070 0

// ==== build.f ====
+incdir+rtl
rtl/mbox_pkg.sv
rtl/req_queue.sv
rtl/stream_beat_pairer.sv
rtl/mbox_controller.sv
rtl/mbox_regfile.sv
rtl/axi_mbox_top.sv
test/axi_mbox_assertions.sv
test/tb_axi_mbox.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_axi_mbox
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
RUN_ARGS   := +verilator+error+limit+100
PASS_MSG   := TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_axi_mbox.sv ====
// trace-driven testbench for the mailbox block, run from the project root
// records are issued in file order with idle gaps so no request queue fills
// local read responses are checked in request order
`timescale 1ns/100ps
`include "mbox_consts.svh"

module tb_axi_mbox
    import mbox_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int GAP_CYCLES   = 2;
    localparam int MAX_RECS     = 128;
    localparam int SETTLE_LIMIT = 40;
    localparam int DRAIN_LIMIT  = 200;

    logic      axi_aclk;
    logic      axi_aresetn;
    logic      ls_wstart;
    reg_addr_t ls_waddr;
    word_t     ls_wdata;
    strb_t     ls_wstrb;
    logic      ls_rstart;
    reg_addr_t ls_raddr;
    word_t     ls_rdata;
    logic      ls_rdone;
    logic      ss_valid;
    word_t     ss_data;
    user_t     ss_user;
    logic      axi_interrupt;

    logic [31:0] rec_op [MAX_RECS];
    logic [31:0] rec_a  [MAX_RECS];
    logic [31:0] rec_b  [MAX_RECS];
    logic [31:0] rec_c  [MAX_RECS];
    int          num_recs;
    logic        loaded;
    word_t       exp_reads [$];
    int          irq_count   = 0;
    int          read_errors = 0;
    int          extra_rdone = 0;
    int          irq_errors;
    int          other_errors;
    int          assert_fails;

    axi_mbox_top dut (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .ls_wstart     (ls_wstart),
        .ls_waddr      (ls_waddr),
        .ls_wdata      (ls_wdata),
        .ls_wstrb      (ls_wstrb),
        .ls_rstart     (ls_rstart),
        .ls_raddr      (ls_raddr),
        .ls_rdata      (ls_rdata),
        .ls_rdone      (ls_rdone),
        .ss_valid      (ss_valid),
        .ss_data       (ss_data),
        .ss_user       (ss_user),
        .axi_interrupt (axi_interrupt)
    );

    bind req_queue axi_mbox_assertions queue_checks (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .push          (push),
        .full          (full),
        .ls_pop        (1'b0),
        .ls_rdone      (1'b0),
        .axi_interrupt (1'b0)
    );

    bind axi_mbox_top axi_mbox_assertions top_checks (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .push          (1'b0),
        .full          (1'b0),
        .ls_pop        (ls_pop),
        .ls_rdone      (ls_rdone),
        .axi_interrupt (axi_interrupt)
    );

    always #2 axi_aclk = ~axi_aclk;

    // --------------------
    // response monitors
    always @(posedge axi_aclk) begin
        if (axi_aresetn && ls_rdone) begin
            if (exp_reads.size() == 0) begin
                $display("read response at %0t without an outstanding read", $time);
                extra_rdone++;
            end else begin
                if (ls_rdata !== exp_reads[0]) begin
                    $display("Error at %0t: read data %h, expected %h",
                             $time, ls_rdata, exp_reads[0]);
                    read_errors++;
                end
                void'(exp_reads.pop_front());
            end
        end
    end

    always @(posedge axi_aclk) begin
        if (axi_aresetn && axi_interrupt) begin
            irq_count++;
        end
    end

    // --------------------
    // trace loading skips lines starting with #
    task automatic load_trace();
        int          fd;
        string       line;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        num_recs = 0;
        fd = $fopen("test/axi_mbox_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file test/axi_mbox_trace.txt");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0 && num_recs < MAX_RECS) begin
            if (line.len() > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%h %h %h %h", op, a, b, c) == 4) begin
                    rec_op[num_recs] = op;
                    rec_a[num_recs]  = a;
                    rec_b[num_recs]  = b;
                    rec_c[num_recs]  = c;
                    num_recs++;
                end
            end
        end
        $fclose(fd);
    endtask

    // --------------------
    // drivers
    task automatic stream_beat(input user_t user, input word_t data);
        @(posedge axi_aclk);
        ss_valid <= 1'b1;
        ss_user  <= user;
        ss_data  <= data;
    endtask

    // drop all strobes, then leave the queues some room
    task automatic finish_request();
        @(posedge axi_aclk);
        ls_wstart <= 1'b0;
        ls_rstart <= 1'b0;
        ss_valid  <= 1'b0;
        repeat (GAP_CYCLES) @(posedge axi_aclk);
    endtask

    task automatic check_irq_count(input int expected);
        int waited;
        waited = 0;
        while (irq_count < expected && waited < SETTLE_LIMIT) begin
            @(posedge axi_aclk);
            waited++;
        end
        if (irq_count != expected) begin
            $display("Error at %0t: interrupt count %0d, expected %0d",
                     $time, irq_count, expected);
            irq_errors++;
        end
    endtask

    task automatic run_record(input int i);
        case (rec_op[i])
            32'd0: begin
                @(posedge axi_aclk);
                ls_wstart <= 1'b1;
                ls_waddr  <= reg_addr_t'(rec_a[i]);
                ls_wdata  <= rec_b[i];
                ls_wstrb  <= strb_t'(rec_c[i]);
                finish_request();
            end
            32'd1: begin
                exp_reads.push_back(rec_b[i]);
                @(posedge axi_aclk);
                ls_rstart <= 1'b1;
                ls_raddr  <= reg_addr_t'(rec_a[i]);
                finish_request();
            end
            32'd2: begin
                // first beat {strb, addr}, then the data beat
                stream_beat(`MBOX_USER_REMOTE_WR, {rec_c[i][3:0], rec_a[i][27:0]});
                stream_beat(`MBOX_USER_REMOTE_WR, rec_b[i]);
                finish_request();
            end
            32'd3: begin
                stream_beat(user_t'(rec_a[i]), rec_b[i]);
                finish_request();
            end
            32'd4: check_irq_count(int'(rec_a[i]));
            32'd5: repeat (rec_a[i]) @(posedge axi_aclk);
            32'd6: begin
                stream_beat(`MBOX_USER_REMOTE_WR, {rec_c[i][3:0], rec_a[i][27:0]});
                finish_request();
            end
            default: begin
                $display("unknown record kind %0h in trace record %0d", rec_op[i], i);
                other_errors++;
            end
        endcase
    endtask

    task automatic wait_for_reads();
        int waited;
        waited = 0;
        while (exp_reads.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge axi_aclk);
            waited++;
        end
        if (exp_reads.size() != 0) begin
            $display("%0d read responses never arrived", exp_reads.size());
            other_errors++;
        end
    endtask

    // --------------------
    // main sequence
    initial begin
        axi_aclk     = 1'b0;
        axi_aresetn  = 1'b0;
        ls_wstart    = 1'b0;
        ls_waddr     = '0;
        ls_wdata     = '0;
        ls_wstrb     = '0;
        ls_rstart    = 1'b0;
        ls_raddr     = '0;
        ss_valid     = 1'b0;
        ss_data      = '0;
        ss_user      = '0;
        irq_errors   = 0;
        other_errors = 0;
        loaded       = 1'b0;
        load_trace();
        if (num_recs == 0) begin
            $display("no records were read from the trace");
            other_errors++;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge axi_aclk);
        axi_aresetn <= 1'b1;
        for (int i = 0; i < num_recs; i++) begin
            run_record(i);
        end
        wait_for_reads();
        assert_fails = dut.ls_queue.queue_checks.fail_count
                     + dut.ss_queue.queue_checks.fail_count
                     + dut.top_checks.fail_count;
        $display("errors: read %0d, irq %0d, stray rdone %0d, other %0d, assert %0d",
                 read_errors, irq_errors, extra_rdone, other_errors, assert_fails);
        if (read_errors == 0 && irq_errors == 0 && extra_rdone == 0
                && other_errors == 0 && assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // run limit scales with the trace length
    initial begin
        wait (loaded);
        repeat ((num_recs + 1) * 40 + RESET_CYCLES) @(posedge axi_aclk);
        $display("watchdog expired before the trace completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== test/axi_mbox_assertions.sv ====
// protocol checks, bound into each request queue and into the top level
// unused inputs are tied low at the bind site
`timescale 1ns/100ps

module axi_mbox_assertions (
    input logic axi_aclk,
    input logic axi_aresetn,
    input logic push,
    input logic full,
    input logic ls_pop,
    input logic ls_rdone,
    input logic axi_interrupt
);

    int fail_count = 0;

    // senders have no back-pressure, so a push while full is lost
    no_push_when_full: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        !(push && full))
        else begin
            fail_count++;
            $error("push into a full request queue");
        end

    rdone_one_cycle: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        ls_rdone |=> !ls_rdone)
        else begin
            fail_count++;
            $error("ls_rdone held for more than one cycle");
        end

    irq_one_cycle: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        axi_interrupt |=> !axi_interrupt)
        else begin
            fail_count++;
            $error("axi_interrupt held for more than one cycle");
        end

    // the cycle after a local pop is CTRL_DECIDE
    no_rdone_in_decide: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        ls_pop |=> !ls_rdone)
        else begin
            fail_count++;
            $error("ls_rdone while a local request is still being decoded");
        end

endmodule

// ==== rtl/axi_mbox_top.sv ====
// mailbox block top: local register port plus inbound stream
// ls_wstart and ls_rstart must never be high together
// no ready on the stream; senders must not overrun the queues
`timescale 1ns/100ps
`include "mbox_consts.svh"

module axi_mbox_top
    import mbox_pkg::*;
(
    input  logic      axi_aclk,
    input  logic      axi_aresetn,
    input  logic      ls_wstart,
    input  reg_addr_t ls_waddr,
    input  word_t     ls_wdata,
    input  strb_t     ls_wstrb,
    input  logic      ls_rstart,
    input  reg_addr_t ls_raddr,
    output word_t     ls_rdata,
    output logic      ls_rdone,
    input  logic      ss_valid,
    input  word_t     ss_data,
    input  user_t     ss_user,
    output logic      axi_interrupt
);

    logic      ls_push;
    ls_entry_t ls_entry;
    logic      ls_pop;
    ls_entry_t ls_head;
    logic      ls_empty;
    logic      ss_push;
    ss_entry_t ss_entry;
    logic      ss_pop;
    ss_entry_t ss_head;
    logic      ss_empty;
    logic      reg_we;
    reg_sel_t  reg_sel;
    mb_index_t reg_index;
    word_t     reg_wdata;
    strb_t     reg_wstrb;
    logic      remote_write;
    word_t     reg_rdata;

    // local request packing, reads carry no data
    assign ls_push  = ls_wstart || ls_rstart;
    assign ls_entry = ls_wstart ? {REQ_WRITE, ls_waddr, ls_wdata, ls_wstrb}
                                : {REQ_READ, ls_raddr, 36'b0};

    req_queue #(
        .WIDTH($bits(ls_entry_t)),
        .DEPTH(`MBOX_QUEUE_DEPTH)
    ) ls_queue (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .push        (ls_push),
        .push_data   (ls_entry),
        .pop         (ls_pop),
        .head_data   (ls_head),
        .empty       (ls_empty)
    );

    stream_beat_pairer u_pairer (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .ss_valid    (ss_valid),
        .ss_data     (ss_data),
        .ss_user     (ss_user),
        .pair_push   (ss_push),
        .pair_entry  (ss_entry)
    );

    req_queue #(
        .WIDTH($bits(ss_entry_t)),
        .DEPTH(`MBOX_QUEUE_DEPTH)
    ) ss_queue (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .push        (ss_push),
        .push_data   (ss_entry),
        .pop         (ss_pop),
        .head_data   (ss_head),
        .empty       (ss_empty)
    );

    mbox_controller u_ctrl (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .ls_empty     (ls_empty),
        .ls_head      (ls_head),
        .ls_pop       (ls_pop),
        .ss_empty     (ss_empty),
        .ss_head      (ss_head),
        .ss_pop       (ss_pop),
        .reg_we       (reg_we),
        .reg_sel      (reg_sel),
        .reg_index    (reg_index),
        .reg_wdata    (reg_wdata),
        .reg_wstrb    (reg_wstrb),
        .remote_write (remote_write),
        .reg_rdata    (reg_rdata),
        .ls_rdata     (ls_rdata),
        .ls_rdone     (ls_rdone)
    );

    mbox_regfile u_regs (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .reg_we        (reg_we),
        .reg_sel       (reg_sel),
        .reg_index     (reg_index),
        .reg_wdata     (reg_wdata),
        .reg_wstrb     (reg_wstrb),
        .remote_write  (remote_write),
        .reg_rdata     (reg_rdata),
        .axi_interrupt (axi_interrupt)
    );

endmodule

// ==== rtl/mbox_regfile.sv ====
// mailbox words plus the two control words
// control words hold only bit 0, other bits read as zero
// the interrupt pulse follows a remote mailbox write while enabled
`timescale 1ns/100ps
`include "mbox_consts.svh"

module mbox_regfile
    import mbox_pkg::*;
(
    input  logic      axi_aclk,
    input  logic      axi_aresetn,
    input  logic      reg_we,
    input  reg_sel_t  reg_sel,
    input  mb_index_t reg_index,
    input  word_t     reg_wdata,
    input  strb_t     reg_wstrb,
    input  logic      remote_write,
    output word_t     reg_rdata,
    output logic      axi_interrupt
);

    word_t mb_regs [`MBOX_MB_WORDS];
    logic  int_en;
    logic  int_status;

    // read mux
    always_comb begin
        if (reg_sel == SEL_MB) begin
            reg_rdata = mb_regs[reg_index];
        end else if (reg_index[0] == 1'b0) begin
            reg_rdata = {31'b0, int_en};
        end else begin
            reg_rdata = {31'b0, int_status};
        end
    end

    // --------------------
    // writes
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            for (int i = 0; i < `MBOX_MB_WORDS; i++) begin
                mb_regs[i] <= '0;
            end
            int_en        <= 1'b0;
            int_status    <= 1'b0;
            axi_interrupt <= 1'b0;
        end else begin
            axi_interrupt <= 1'b0;
            if (reg_we && reg_sel == SEL_MB) begin
                // byte lanes
                for (int b = 0; b < 4; b++) begin
                    if (reg_wstrb[b]) begin
                        mb_regs[reg_index][8*b +: 8] <= reg_wdata[8*b +: 8];
                    end
                end
                if (remote_write && int_en) begin
                    int_status    <= 1'b1;
                    axi_interrupt <= 1'b1;
                end
            end else if (reg_we && reg_wstrb[0]) begin
                if (reg_index[0] == 1'b0) begin
                    int_en <= reg_wdata[0];
                end else if (reg_wdata[0]) begin
                    // write one to clear
                    int_status <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== rtl/mbox_controller.sv ====
// drains the local and remote queues, three cycles per request
// both queues pending: the source not served last goes first
// remote requests only ever write the mailbox words
`timescale 1ns/100ps
`include "mbox_consts.svh"

module mbox_controller
    import mbox_pkg::*;
(
    input  logic      axi_aclk,
    input  logic      axi_aresetn,
    input  logic      ls_empty,
    input  ls_entry_t ls_head,
    output logic      ls_pop,
    input  logic      ss_empty,
    input  ss_entry_t ss_head,
    output logic      ss_pop,
    output logic      reg_we,
    output reg_sel_t  reg_sel,
    output mb_index_t reg_index,
    output word_t     reg_wdata,
    output strb_t     reg_wstrb,
    output logic      remote_write,
    input  word_t     reg_rdata,
    output word_t     ls_rdata,
    output logic      ls_rdone
);

    ctrl_state_t  state;
    src_t         last_src;
    logic         take_ls;
    logic         take_ss;
    src_t         cur_src;
    req_kind_t    cur_kind;
    remote_addr_t cur_addr;
    word_t        cur_data;
    strb_t        cur_strb;
    logic         in_block;
    logic         mb_hit;
    logic         aa_hit;
    logic         hit_q;
    reg_sel_t     sel_q;
    mb_index_t    index_q;

    // --------------------
    // source pick
    assign take_ls = !ls_empty && (ss_empty || last_src == SRC_SS);
    assign take_ss = !ss_empty && !take_ls;
    assign ls_pop  = (state == CTRL_IDLE) && take_ls;
    assign ss_pop  = (state == CTRL_IDLE) && take_ss;

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state    <= CTRL_IDLE;
            last_src <= SRC_LS;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    if (take_ls || take_ss) begin
                        state    <= CTRL_DECIDE;
                        last_src <= take_ss ? SRC_SS : SRC_LS;
                    end
                end
                CTRL_DECIDE: state <= CTRL_EXEC;
                default:     state <= CTRL_IDLE;
            endcase
        end
    end

    // latch the popped head, local address zero-extended
    always_ff @(posedge axi_aclk) begin
        if (ls_pop) begin
            cur_src  <= SRC_LS;
            cur_kind <= req_kind_t'(ls_head[51]);
            cur_addr <= {13'b0, ls_head[50:36]};
            cur_data <= ls_head[35:4];
            cur_strb <= ls_head[3:0];
        end else if (ss_pop) begin
            cur_src  <= SRC_SS;
            cur_kind <= REQ_WRITE;
            cur_strb <= ss_head[63:60];
            cur_addr <= ss_head[59:32];
            cur_data <= ss_head[31:0];
        end
    end

    // --------------------
    // address decode
    assign in_block = (cur_addr >= `MBOX_MB_FIRST) && (cur_addr <= `MBOX_LOCAL_LAST);
    assign mb_hit   = in_block && (cur_addr <= `MBOX_MB_LAST);
    assign aa_hit   = in_block && (cur_addr >= `MBOX_AA_FIRST) && (cur_addr <= `MBOX_AA_LAST);

    always_ff @(posedge axi_aclk) begin
        if (state == CTRL_DECIDE) begin
            hit_q   <= mb_hit || (aa_hit && cur_src == SRC_LS);
            sel_q   <= mb_hit ? SEL_MB : SEL_AA;
            index_q <= mb_hit ? mb_index_t'((cur_addr - `MBOX_MB_FIRST) >> 2)
                              : mb_index_t'((cur_addr - `MBOX_AA_FIRST) >> 2);
        end
    end

    // --------------------
    // register access and read response
    assign reg_we       = (state == CTRL_EXEC) && hit_q && (cur_kind == REQ_WRITE);
    assign remote_write = reg_we && (cur_src == SRC_SS);
    assign reg_sel      = sel_q;
    assign reg_index    = index_q;
    assign reg_wdata    = cur_data;
    assign reg_wstrb    = cur_strb;

    assign ls_rdone = (state == CTRL_EXEC) && (cur_src == SRC_LS) && (cur_kind == REQ_READ);
    assign ls_rdata = hit_q ? reg_rdata : `MBOX_UNSUPP_DATA;

endmodule

// ==== rtl/stream_beat_pairer.sv ====
// joins a remote write sent as two stream beats into one queue entry
// first beat {strb[3:0], addr[27:0]}, second beat the data word
// any beat with another user code drops a half-received pair
`timescale 1ns/100ps
`include "mbox_consts.svh"

module stream_beat_pairer
    import mbox_pkg::*;
(
    input  logic      axi_aclk,
    input  logic      axi_aresetn,
    input  logic      ss_valid,
    input  word_t     ss_data,
    input  user_t     ss_user,
    output logic      pair_push,
    output ss_entry_t pair_entry
);

    logic  held;
    word_t first_beat;
    logic  wr_beat;

    assign wr_beat = ss_valid && (ss_user == `MBOX_USER_REMOTE_WR);

    // second beat completes the pair in the same cycle
    assign pair_push  = wr_beat && held;
    assign pair_entry = {first_beat[31:28], first_beat[27:0], ss_data};

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            held <= 1'b0;
        end else if (ss_valid) begin
            held <= wr_beat && !held;
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (wr_beat && !held) begin
            first_beat <= ss_data;
        end
    end

endmodule

// ==== rtl/req_queue.sv ====
// request FIFO with single-cycle push and pop strobes, no back-pressure
// a push while full is dropped; senders must stay within DEPTH
`timescale 1ns/100ps

module req_queue #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             axi_aclk,
    input  logic             axi_aresetn,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head_data,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign do_push   = push && !full;
    assign do_pop    = pop && !empty;
    assign head_data = mem[rd_ptr];

    // storage
    always_ff @(posedge axi_aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at DEPTH, not at a power of two
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

// ==== rtl/mbox_pkg.sv ====
// types shared by the mailbox block
// queue entries are flat vectors; field order is fixed by the producers
package mbox_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [14:0] reg_addr_t;
    typedef logic [27:0] remote_addr_t;
    typedef logic [1:0]  user_t;
    typedef logic [2:0]  mb_index_t;

    // {kind, addr[14:0], data[31:0], strb[3:0]}
    typedef logic [51:0] ls_entry_t;
    // {strb[3:0], addr[27:0], data[31:0]}
    typedef logic [63:0] ss_entry_t;

    typedef enum logic {REQ_WRITE, REQ_READ} req_kind_t;
    typedef enum logic {SRC_LS, SRC_SS} src_t;
    typedef enum logic {SEL_MB, SEL_AA} reg_sel_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_DECIDE,
        CTRL_EXEC
    } ctrl_state_t;

endpackage

// ==== rtl/mbox_consts.svh ====
// address map and sizing of the mailbox block
// byte addresses are local; remote addresses compare zero-extended
// the two control words must stay inside one mailbox index range
`ifndef MBOX_CONSTS_SVH
`define MBOX_CONSTS_SVH

// mailbox words
`define MBOX_MB_FIRST       32'h0000_2000
`define MBOX_MB_LAST        32'h0000_201F
`define MBOX_MB_WORDS       8

// control words, interrupt enable then status
`define MBOX_AA_FIRST       32'h0000_2100
`define MBOX_AA_LAST        32'h0000_2107

// end of the local block, reads up to here return all ones
`define MBOX_LOCAL_LAST     32'h0000_2FFF

`define MBOX_QUEUE_DEPTH    8
`define MBOX_UNSUPP_DATA    32'hFFFF_FFFF
`define MBOX_USER_REMOTE_WR 2'd1

`endif
